// ==== compile.f ====
verilog/smc_state_pkg.sv
verilog/smc_timing_pkg.sv
verilog/smc_write_timing.sv
verilog/smc_read_timing.sv
verilog/smc_strobe_drive.sv
verilog/smc_strobe_top.sv
sim/smc_strobe_checker.sv
sim/smc_strobe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the strobe generator simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module smc_strobe_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vsmc_strobe_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test completed successfully" sim.log; then
   exit 0
fi
exit 1

// ==== sim/smc_strobe_checker.sv ====
// Strobe generator reference checker
`timescale 1ns/1ps

module smc_strobe_checker
(
   input  logic                        sys_clk25,
   input  logic                        n_sys_reset25,
   input  smc_timing_pkg::smc_access_t access,
   input  smc_timing_pkg::smc_timing_t timing,
   input  smc_state_pkg::smc_state_t   r_smc_currentstate,
   input  smc_state_pkg::smc_state_t   smc_nextstate,
   input  logic                        smc_done,
   input  logic                        mac_done,
   input  logic                        smc_n_rd,
   input  logic                        smc_n_ext_oe,
   input  logic                        smc_busy,
   input  logic                        n_r_read,
   input  logic                        r_cs,
   input  logic                        r_full,
   input  logic                        smc_half_cycle,
   input  logic [3:0]                  n_r_we,
   input  logic                        n_r_wr,
   output int                          error_count,
   output int                          check_count
);

   import smc_state_pkg::*;
   import smc_timing_pkg::*;

   // Model registers one edge behind the inputs
   logic       m_n_rd, m_n_ext_oe, m_busy, m_n_r_read, m_r_cs, m_r_full, m_n_r_wr;
   logic [3:0] m_n_r_we;
   logic       full_n, half_n, window, va, wr_cond, oe_cond;
   logic [1:0] wete_p1;
   logic       reset_seen;                      // Reset sampled at an earlier edge

   initial
   begin
      error_count = 0;
      check_count = 0;
      reset_seen  = 1'b0;
   end

   // Trailing edge ahead of phase or whole groups left
   function automatic logic full_term(input logic [1:0] edge_pos, input logic [7:0] ws,
                                      input logic ok);
      full_term = ok && ((edge_pos < ws[1:0]) || (ws[7:2] != 6'd0));
   endfunction

   function automatic logic half_term(input logic [1:0] edge_pos, input logic [7:0] ws,
                                      input logic ok, input logic use_zero);
      half_term = (ok && edge_pos == ws[1:0] && ws[7:2] == 6'd0)
                  || (use_zero && ws == 8'd0);
   endfunction

   task automatic compare(input string name, input logic [3:0] exp_v, input logic [3:0] got);
      if (exp_v !== got)
      begin
         error_count++;
         $display("MISMATCH at %0t: %0s expected %0h got %0h", $time, name, exp_v, got);
      end
   endtask

   //------------------------------------------------------------
   // Compare then step the model
   //------------------------------------------------------------

   always @(posedge sys_clk25)
   begin
      check_count++;
      if (!n_sys_reset25)
      begin
         if (reset_seen)                        // Outputs settle at the first reset edge
         begin
            compare("smc_n_rd", 4'(1), 4'(smc_n_rd));
            compare("smc_n_ext_oe", 4'(1), 4'(smc_n_ext_oe));
            compare("smc_busy", 4'(0), 4'(smc_busy));
            compare("n_r_read", 4'(0), 4'(n_r_read));
            compare("r_cs", 4'(0), 4'(r_cs));
            compare("r_full", 4'(0), 4'(r_full));
            compare("n_r_we", 4'hf, n_r_we);
            compare("n_r_wr", 4'(1), 4'(n_r_wr));
         end
         reset_seen = 1'b1;
         {m_n_rd, m_n_ext_oe, m_n_r_wr} = 3'b111;
         {m_busy, m_n_r_read, m_r_cs, m_r_full} = 4'b0000;
         m_n_r_we = 4'hf;
      end
      else
      begin
         compare("smc_n_rd", 4'(m_n_rd), 4'(smc_n_rd));
         compare("smc_n_ext_oe", 4'(m_n_ext_oe), 4'(smc_n_ext_oe));
         compare("smc_busy", 4'(m_busy), 4'(smc_busy));
         compare("n_r_read", 4'(m_n_r_read), 4'(n_r_read));
         compare("r_cs", 4'(m_r_cs), 4'(r_cs));
         compare("r_full", 4'(m_r_full), 4'(r_full));
         compare("n_r_we", m_n_r_we, n_r_we);
         compare("n_r_wr", 4'(m_n_r_wr), 4'(n_r_wr));
         va = access.valid_access;
         // Write timing
         full_n  = 1'b0;
         half_n  = 1'b0;
         wete_p1 = timing.wete_store + 2'd1;
         if (smc_nextstate == SMC_RW)
         begin
            if (r_smc_currentstate == SMC_LE || r_smc_currentstate == SMC_STORE)
            begin
               full_n = full_term(timing.wete_store, timing.ws_count.raw,
                                  (r_smc_currentstate == SMC_LE) ? timing.wele_count < 2'd2
                                                                 : timing.wele_count == 2'd0);
               half_n = half_term(timing.wete_store, timing.ws_count.raw,
                                  timing.wele_count < 2'd2, 1'b1);
            end
            else if (r_smc_currentstate == SMC_RW || r_smc_currentstate == SMC_FLOAT)
            begin
               if (va)
               begin
                  full_n = 1'b0;
                  half_n = 1'b0;
               end
               else if (smc_done)
               begin
                  full_n = full_term(timing.wete_store, timing.ws_store.raw,
                                     timing.wele_store == 2'd0);
                  half_n = half_term(timing.wete_store, timing.ws_store.raw,
                                     timing.wele_store == 2'd0, 1'b1);
               end
               else if (timing.wete_store == 2'd3)
               begin
                  full_n = timing.ws_count.raw > 8'd4 && timing.wele_count < 2'd2;
                  half_n = timing.ws_count.raw == 8'd4 && timing.wele_count < 2'd2;
               end
               else
               begin
                  full_n = full_term(wete_p1, timing.ws_count.raw, timing.wele_count < 2'd2);
                  half_n = half_term(wete_p1, timing.ws_count.raw,
                                     timing.wele_count < 2'd2, 1'b0);
               end
            end
         end
         compare("smc_half_cycle", 4'(half_n & ~m_r_full), 4'(smc_half_cycle));
         // Read window
         if (r_smc_currentstate == SMC_LE || r_smc_currentstate == SMC_STORE)
            window = timing.oete_store < timing.ws_store.raw[1:0]
                     || timing.ws_store.raw[7:2] != 6'd0
                     || timing.oete_store == timing.ws_store.raw[1:0]
                     || timing.ws_store.raw == 8'd0;
         else
            window = timing.oete_store < timing.ws_count.raw[1:0]
                     || timing.ws_count.raw[7:2] != 6'd0
                     || timing.ws_count.raw == 8'd0;
         // Strobes use the held direction from before this edge
         wr_cond = smc_nextstate != SMC_STORE
                   && ((va && access.n_read) || (m_n_r_read && !va));
         oe_cond = smc_nextstate != SMC_STORE
                   && ((va && access.n_read)
                       || (m_n_r_read && !va && smc_nextstate != SMC_IDLE));
         if (smc_nextstate != SMC_RW)
            m_n_rd = 1'b1;
         else if (va)
            m_n_rd = access.n_read;
         else
            m_n_rd = window ? m_n_r_read : 1'b1;
         m_n_r_we   = wr_cond ? access.n_be : 4'hf;
         m_n_r_wr   = !wr_cond;
         m_n_ext_oe = !oe_cond;
         m_busy     = smc_nextstate != SMC_IDLE;
         m_r_full   = full_n;
         if (va)
         begin
            m_n_r_read = access.n_read;
            m_r_cs     = access.cs;
         end
         else if (smc_done && mac_done)
         begin
            m_n_r_read = 1'b0;
            m_r_cs     = 1'b0;
         end
      end
   end

endmodule

// ==== sim/smc_strobe_tb.sv ====
// Strobe generator testbench
`timescale 1ns/1ps

module smc_strobe_tb;

   import smc_state_pkg::*;
   import smc_timing_pkg::*;

   logic        sys_clk25;
   logic        n_sys_reset25;
   smc_access_t access;
   smc_timing_t timing;
   smc_state_t  r_smc_currentstate;
   smc_state_t  smc_nextstate;
   logic        smc_done;
   logic        mac_done;
   logic        smc_n_rd;
   logic        smc_n_ext_oe;
   logic        smc_busy;
   logic        n_r_read;
   logic        r_cs;
   logic        r_full;
   logic        smc_half_cycle;
   logic [3:0]  n_r_we;
   logic        n_r_wr;
   int          error_count;
   int          check_count;
   integer      seed;
   int          tests_run;
   int          tests_failed;

   smc_strobe_top UUT
   (
      .sys_clk25(sys_clk25), .n_sys_reset25(n_sys_reset25), .access(access),
      .timing(timing), .r_smc_currentstate(r_smc_currentstate),
      .smc_nextstate(smc_nextstate), .smc_done(smc_done), .mac_done(mac_done),
      .smc_n_rd(smc_n_rd), .smc_n_ext_oe(smc_n_ext_oe), .smc_busy(smc_busy),
      .n_r_read(n_r_read), .r_cs(r_cs), .r_full(r_full),
      .smc_half_cycle(smc_half_cycle), .n_r_we(n_r_we), .n_r_wr(n_r_wr)
   );

   smc_strobe_checker u_checker
   (
      .sys_clk25(sys_clk25), .n_sys_reset25(n_sys_reset25), .access(access),
      .timing(timing), .r_smc_currentstate(r_smc_currentstate),
      .smc_nextstate(smc_nextstate), .smc_done(smc_done), .mac_done(mac_done),
      .smc_n_rd(smc_n_rd), .smc_n_ext_oe(smc_n_ext_oe), .smc_busy(smc_busy),
      .n_r_read(n_r_read), .r_cs(r_cs), .r_full(r_full),
      .smc_half_cycle(smc_half_cycle), .n_r_we(n_r_we), .n_r_wr(n_r_wr),
      .error_count(error_count), .check_count(check_count)
   );

   //------------------------------------------------------------
   // Clock with 40 ns period
   //------------------------------------------------------------

   initial
   begin
      sys_clk25 = 1'b0;
      forever #20 sys_clk25 = ~sys_clk25;
   end

   // Non-negative random number below lim
   function automatic int rand_below(input int lim);
      int r;
      r = $random(seed);
      rand_below = (r & 32'h7fff_ffff) % lim;
   endfunction

   function automatic smc_state_t state_from_index(input int idx);
      case (idx)
         1:       state_from_index = SMC_LE;
         2:       state_from_index = SMC_RW;
         3:       state_from_index = SMC_STORE;
         4:       state_from_index = SMC_FLOAT;
         default: state_from_index = SMC_IDLE;
      endcase
   endfunction

   // Wait-state word with count 0 and group 1 made common
   function automatic logic [7:0] pick_ws_word();
      logic [7:0] w;
      w = 8'(rand_below(256));
      case (rand_below(4))
         0:       pick_ws_word = 8'h00;
         1:       pick_ws_word = {6'd1, w[1:0]};
         2:       pick_ws_word = {5'd0, w[2:0]};
         default: pick_ws_word = w;
      endcase
   endfunction

   // One cycle of stimulus biased per test mode
   task automatic drive_cycle(input int mode);
      smc_access_t a;
      smc_timing_t t;
      @(posedge sys_clk25);
      a.valid_access = (rand_below(4) == 0);
      a.n_read       = 1'(rand_below(2));
      a.cs           = 1'(rand_below(2));
      a.n_be         = 4'(rand_below(16));
      t.wele_count   = 2'(rand_below(4));
      t.wele_store   = 2'(rand_below(4));
      t.wete_store   = 2'(rand_below(4));
      t.oete_store   = 2'(rand_below(4));
      t.ws_count.raw = pick_ws_word();
      t.ws_store.raw = pick_ws_word();
      if (mode == 5 && rand_below(2) == 0)
         t.wete_store = 2'd3;                   // Latest trailing edge
      access             <= a;
      timing             <= t;
      r_smc_currentstate <= state_from_index(rand_below(5));
      if ((mode == 4 || mode == 5) && rand_below(4) != 0)
         smc_nextstate <= SMC_RW;               // Favour strobe phase
      else
         smc_nextstate <= state_from_index(rand_below(5));
      smc_done <= (mode == 2) ? (rand_below(2) == 0) : (rand_below(4) == 0);
      mac_done <= (mode == 2) ? (rand_below(2) == 0) : (rand_below(3) == 0);
   endtask

   // Run one test and report it once the checker catches up
   task automatic run_test(input int mode, input string name, input int cycles);
      int errs_before;
      int target;
      int waited;
      errs_before = error_count;
      target      = check_count + cycles + 1;
      for (int i = 0; i < cycles; i++)
      begin
         drive_cycle(mode);
         if (mode == 1 && i == 7)
            n_sys_reset25 <= 1'b1;              // Reset held 8 cycles
      end
      waited = 0;
      while (check_count < target && waited < 100)
      begin
         @(negedge sys_clk25);
         waited++;
      end
      if (check_count < target)
      begin
         $display("Timeout: checker stopped comparing during test %0s", name);
         $display("Test failed");
         $finish;
      end
      tests_run++;
      if (error_count == errs_before)
         $display("Test %0d %0s: PASS", tests_run, name);
      else
      begin
         tests_failed++;
         $display("Test %0d %0s: FAIL, %0d errors", tests_run, name,
                  error_count - errs_before);
      end
   endtask

   initial
   begin
      seed               = 32'hf080_6cd6;
      tests_run          = 0;
      tests_failed       = 0;
      n_sys_reset25      = 1'b0;
      access             = '0;
      timing             = '0;
      r_smc_currentstate = SMC_IDLE;
      smc_nextstate      = SMC_IDLE;
      smc_done           = 1'b0;
      mac_done           = 1'b0;
      run_test(1, "reset values", 10);
      run_test(2, "cycle hold", 300);
      run_test(3, "write path", 300);
      run_test(4, "read path", 300);
      run_test(5, "write timing", 400);
      run_test(6, "mixed run", 2000);
      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0 && tests_failed == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== verilog/smc_read_timing.sv ====
// Read strobe window
`timescale 1ns/1ps

module smc_read_timing
(
   input  smc_state_pkg::smc_state_t   r_smc_currentstate,
   input  smc_timing_pkg::smc_timing_t timing,
   output logic                        rd_window
);

   import smc_state_pkg::*;
   import smc_timing_pkg::*;

   logic     from_store;                        // Counter reloads this cycle
   ws_word_u ws;                                // Wait-state word in use
   logic     oe_before;                         // OE edge ahead of phase
   logic     group_left;                        // Whole groups still to go
   logic     oe_on_phase;                       // OE edge on last phase
   logic     count_zero;                        // No wait states

   //------------------------------------------------------------
   // Select wait-state source
   //------------------------------------------------------------

   // LE and STORE see the counter before its reload
   assign from_store = (r_smc_currentstate == SMC_LE)
                       || (r_smc_currentstate == SMC_STORE);
   assign ws         = from_store ? timing.ws_store : timing.ws_count;

   //------------------------------------------------------------
   // Window rule
   //------------------------------------------------------------

   assign oe_before   = timing.oete_store < ws.split.ws_lo;
   assign group_left  = ws.split.ws_hi != '0;
   assign oe_on_phase = (timing.oete_store == ws.split.ws_lo) && !group_left;
   assign count_zero  = ws.raw == '0;

   // Exact phase match only counts from the stored value
   assign rd_window = oe_before || group_left || count_zero
                      || (from_store && oe_on_phase);

endmodule

// ==== verilog/smc_state_pkg.sv ====
// Controller state encoding
package smc_state_pkg;

   //------------------------------------------------------------
   // State word
   //------------------------------------------------------------

   localparam int SMC_STATE_W = 5;          // One bit per state

   // One-hot controller states, driven by the external FSM
   typedef enum logic [SMC_STATE_W-1:0]
   {
      SMC_IDLE  = 5'b00001,                 // No access in progress
      SMC_LE    = 5'b00010,                 // Leading edge wait
      SMC_RW    = 5'b00100,                 // Read/write strobe phase
      SMC_STORE = 5'b01000,                 // Store read data
      SMC_FLOAT = 5'b10000                  // Bus turnaround
   } smc_state_t;

endpackage

// ==== verilog/smc_strobe_drive.sv ====
// Strobe output registers
`timescale 1ns/1ps

module smc_strobe_drive
(
   input  logic                              sys_clk25,
   input  logic                              n_sys_reset25,
   input  smc_timing_pkg::smc_access_t       access,
   input  smc_state_pkg::smc_state_t         r_smc_currentstate,
   input  smc_state_pkg::smc_state_t         smc_nextstate,
   input  logic                              smc_done,
   input  logic                              mac_done,
   input  logic                              rd_window,
   output logic                              smc_n_rd,
   output logic                              smc_n_ext_oe,
   output logic                              smc_busy,
   output logic                              n_r_read,
   output logic                              r_cs,
   output logic [smc_timing_pkg::BE_W-1:0]   n_r_we,
   output logic                              n_r_wr
);

   import smc_state_pkg::*;

   logic mac_clear;                             // Last access of a burst
   logic wr_new;                                // New write request
   logic wr_held;                               // Write still in progress
   logic next_store;                            // Heading into STORE
   logic next_idle;                             // Heading into IDLE
   logic next_rw;                               // Heading into strobe phase
   logic write_cond;                            // Drive write strobes
   logic oe_cond;                               // Drive external bus

   assign mac_clear  = smc_done & mac_done;
   assign wr_new     = access.valid_access & access.n_read;
   assign wr_held    = n_r_read & ~access.valid_access;
   assign next_store = smc_nextstate == SMC_STORE;
   assign next_idle  = smc_nextstate == SMC_IDLE;
   assign next_rw    = smc_nextstate == SMC_RW;
   assign write_cond = ~next_store & (wr_new | wr_held);
   assign oe_cond    = ~next_store & (wr_new | (wr_held & ~next_idle));

   //------------------------------------------------------------
   // Cycle hold and busy
   //------------------------------------------------------------

   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
      begin
         n_r_read <= 1'b0;
         r_cs     <= 1'b0;
         smc_busy <= 1'b0;
      end
      else
      begin
         if (access.valid_access)
         begin
            n_r_read <= access.n_read;         // Latch direction
            r_cs     <= access.cs;
         end
         else if (mac_clear)
         begin
            n_r_read <= 1'b0;                  // Burst finished
            r_cs     <= 1'b0;
         end
         smc_busy <= ~next_idle;
      end
   end

   //------------------------------------------------------------
   // Write enables and bus drive
   //------------------------------------------------------------

   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
      begin
         n_r_we       <= '1;
         n_r_wr       <= 1'b1;
         smc_n_ext_oe <= 1'b1;
      end
      else
      begin
         n_r_we       <= write_cond ? access.n_be : '1;  // Byte lanes follow n_be
         n_r_wr       <= ~write_cond;
         smc_n_ext_oe <= ~oe_cond;             // Bus driven only for writes
      end
   end

   //------------------------------------------------------------
   // Read strobe
   //------------------------------------------------------------

   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
      begin
         smc_n_rd <= 1'b1;
      end
      else if (next_rw)
      begin
         if (access.valid_access)
         begin
            smc_n_rd <= access.n_read;         // First cycle of access
         end
         else
         begin
            smc_n_rd <= rd_window ? n_r_read : 1'b1;
         end
      end
      else
      begin
         smc_n_rd <= 1'b1;
      end
   end

endmodule

// ==== verilog/smc_strobe_top.sv ====
// Static memory strobe generator
`timescale 1ns/1ps

module smc_strobe_top
(
   input  logic                              sys_clk25,
   input  logic                              n_sys_reset25,
   input  smc_timing_pkg::smc_access_t       access,
   input  smc_timing_pkg::smc_timing_t       timing,
   input  smc_state_pkg::smc_state_t         r_smc_currentstate,
   input  smc_state_pkg::smc_state_t         smc_nextstate,
   input  logic                              smc_done,
   input  logic                              mac_done,
   output logic                              smc_n_rd,
   output logic                              smc_n_ext_oe,
   output logic                              smc_busy,
   output logic                              n_r_read,
   output logic                              r_cs,
   output logic                              r_full,
   output logic                              smc_half_cycle,
   output logic [smc_timing_pkg::BE_W-1:0]   n_r_we,
   output logic                              n_r_wr
);

   logic rd_window;                             // Read strobe allowed

   // Full and half cycle write qualifiers
   smc_write_timing u_write_timing
   (
      .sys_clk25          (sys_clk25),
      .n_sys_reset25      (n_sys_reset25),
      .r_smc_currentstate (r_smc_currentstate),
      .smc_nextstate      (smc_nextstate),
      .timing             (timing),
      .valid_access       (access.valid_access),
      .smc_done           (smc_done),
      .r_full             (r_full),
      .half_cycle         (smc_half_cycle)
   );

   // OE trailing edge against wait states
   smc_read_timing u_read_timing
   (
      .r_smc_currentstate (r_smc_currentstate),
      .timing             (timing),
      .rd_window          (rd_window)
   );

   //------------------------------------------------------------
   // Registered strobes
   //------------------------------------------------------------

   smc_strobe_drive u_strobe_drive
   (
      .sys_clk25          (sys_clk25),
      .n_sys_reset25      (n_sys_reset25),
      .access             (access),
      .r_smc_currentstate (r_smc_currentstate),
      .smc_nextstate      (smc_nextstate),
      .smc_done           (smc_done),
      .mac_done           (mac_done),
      .rd_window          (rd_window),
      .smc_n_rd           (smc_n_rd),
      .smc_n_ext_oe       (smc_n_ext_oe),
      .smc_busy           (smc_busy),
      .n_r_read           (n_r_read),
      .r_cs               (r_cs),
      .n_r_we             (n_r_we),
      .n_r_wr             (n_r_wr)
   );

endmodule

// ==== verilog/smc_timing_pkg.sv ====
// Strobe timing types
package smc_timing_pkg;

   //------------------------------------------------------------
   // Widths
   //------------------------------------------------------------

   localparam int WS_W     = 8;             // Wait-state count
   localparam int EDGE_W   = 2;             // Edge settings
   localparam int BE_W     = 4;             // Byte enables
   localparam int EDGE_MAX = 3;             // Latest edge setting

   //------------------------------------------------------------
   // Wait-state word
   //------------------------------------------------------------

   // Count seen whole or as groups of four plus a phase
   typedef union packed
   {
      logic [WS_W-1:0] raw;                 // Whole count
      struct packed
      {
         logic [WS_W-EDGE_W-1:0] ws_hi;     // Groups of four cycles
         logic [EDGE_W-1:0]      ws_lo;     // Phase within group
      } split;
   } ws_word_u;

   // Timing registers supplied by the controller
   typedef struct packed
   {
      logic [EDGE_W-1:0] wele_count;        // Write leading edge counter
      logic [EDGE_W-1:0] wele_store;        // Write leading edge setting
      logic [EDGE_W-1:0] wete_store;        // Write trailing edge setting
      logic [EDGE_W-1:0] oete_store;        // Output enable trailing edge
      ws_word_u          ws_count;          // Running wait-state count
      ws_word_u          ws_store;          // Programmed wait states
   } smc_timing_t;

   // Access request from the controller
   typedef struct packed
   {
      logic            valid_access;        // Load new access values
      logic            n_read;              // Low for read
      logic            cs;                  // Chip select
      logic [BE_W-1:0] n_be;                // Active-low byte enables
   } smc_access_t;

endpackage

// ==== verilog/smc_write_timing.sv ====
// Write strobe timing
`timescale 1ns/1ps

module smc_write_timing
(
   input  logic                        sys_clk25,
   input  logic                        n_sys_reset25,
   input  smc_state_pkg::smc_state_t   r_smc_currentstate,
   input  smc_state_pkg::smc_state_t   smc_nextstate,
   input  smc_timing_pkg::smc_timing_t timing,
   input  logic                        valid_access,
   input  logic                        smc_done,
   output logic                        r_full,
   output logic                        half_cycle
);

   import smc_state_pkg::*;
   import smc_timing_pkg::*;

   //------------------------------------------------------------
   // Edge rules
   //------------------------------------------------------------

   // Full cycle when the trailing edge falls before the count ends
   function automatic logic full_rule
   (
      input logic [EDGE_W-1:0] edge_pos,
      input ws_word_u          ws,
      input logic              wele_ok
   );
      full_rule = ((edge_pos < ws.split.ws_lo) || (ws.split.ws_hi != '0)) && wele_ok;
   endfunction

   // Half cycle when the edge lands on the last phase
   function automatic logic half_rule
   (
      input logic [EDGE_W-1:0] edge_pos,
      input ws_word_u          ws,
      input logic              wele_ok,
      input logic              zero_ok
   );
      half_rule = ((edge_pos == ws.split.ws_lo) && (ws.split.ws_hi == '0) && wele_ok)
                  || (zero_ok && (ws.raw == '0));
   endfunction

   //------------------------------------------------------------
   // Shared terms
   //------------------------------------------------------------

   logic              wele_lt2;                 // Leading edge nearly done
   logic              wele_cnt_zero;            // Leading edge counter expired
   logic              wele_str_zero;            // No leading edge programmed
   logic              wete_last;                // Trailing edge at latest phase
   logic [EDGE_W-1:0] wete_inc;                 // Trailing edge one phase on
   logic              full_d;                   // Next full-cycle flag
   logic              half_raw;                 // Half cycle before masking

   assign wele_lt2      = timing.wele_count < EDGE_W'(2);
   assign wele_cnt_zero = timing.wele_count == '0;
   assign wele_str_zero = timing.wele_store == '0;
   assign wete_last     = timing.wete_store == EDGE_W'(EDGE_MAX);
   assign wete_inc      = timing.wete_store + EDGE_W'(1); // No wrap as wete_last takes 3

   //------------------------------------------------------------
   // Per-state decode
   //------------------------------------------------------------

   always_comb
   begin
      full_d   = 1'b0;
      half_raw = 1'b0;
      if (smc_nextstate == SMC_RW)              // Only entering the strobe phase
      begin
         case (r_smc_currentstate)
            SMC_LE:
            begin
               full_d   = full_rule(timing.wete_store, timing.ws_count, wele_lt2);
               half_raw = half_rule(timing.wete_store, timing.ws_count, wele_lt2, 1'b1);
            end
            SMC_STORE:
            begin
               // Stricter leading edge check after a store
               full_d   = full_rule(timing.wete_store, timing.ws_count, wele_cnt_zero);
               half_raw = half_rule(timing.wete_store, timing.ws_count, wele_lt2, 1'b1);
            end
            SMC_RW, SMC_FLOAT:
            begin
               if (valid_access)
               begin
                  full_d   = 1'b0;              // Fresh access restarts timing
                  half_raw = 1'b0;
               end
               else if (smc_done)
               begin
                  // Back to back access reloads the counters from the stores
                  full_d   = full_rule(timing.wete_store, timing.ws_store, wele_str_zero);
                  half_raw = half_rule(timing.wete_store, timing.ws_store, wele_str_zero, 1'b1);
               end
               else if (wete_last)
               begin
                  full_d   = (timing.ws_count.raw > WS_W'(4)) && wele_lt2;
                  half_raw = (timing.ws_count.split.ws_lo == '0)
                             && (timing.ws_count.split.ws_hi == (WS_W-EDGE_W)'(1))
                             && wele_lt2;
               end
               else
               begin
                  full_d   = full_rule(wete_inc, timing.ws_count, wele_lt2);
                  half_raw = half_rule(wete_inc, timing.ws_count, wele_lt2, 1'b0);
               end
            end
            default:
            begin
               full_d   = 1'b0;                 // Idle never starts a write
               half_raw = 1'b0;
            end
         endcase
      end
   end

   //------------------------------------------------------------
   // Outputs
   //------------------------------------------------------------

   always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
   begin
      if (!n_sys_reset25)
      begin
         r_full <= 1'b0;
      end
      else
      begin
         r_full <= full_d;
      end
   end

   assign half_cycle = half_raw & ~r_full;      // Full cycle overrides half

endmodule
